// File: files.f
verilog/fft_pkg.sv
verilog/cplx_mult.sv
verilog/sample_fifo.sv
verilog/twiddle_rom.sv
verilog/but_wing.sv
verilog/fft_bfly_top.sv
test/tb_fft_bfly.sv

// File: run.sh
#!/bin/sh
# Build and run the butterfly testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module tb_fft_bfly \
  -f files.f \
  -o tb_fft_bfly

./obj_dir/tb_fft_bfly

// File: test/tb_fft_bfly.sv
`timescale 1ns/10ps

module tb_fft_bfly;

  localparam int MUL_LAT = 3;
  localparam int N_BURST = 200;

  logic clk = 1'b0;
  logic rst_n;
  logic sample_valid;
  fft_pkg::cplx_t sample_a;
  fft_pkg::cplx_t sample_b;
  fft_pkg::twdl_idx_t twdl_idx;
  fft_pkg::cplx_t res;
  logic res_valid;
  logic bffr_ovrflw;
  logic bffr_underflw;

  int seed = 85;
  // Reference twiddles, Q8, W(k) = cos - j*sin of 2*pi*k/16
  int tw_re [8] = '{256, 237, 181, 98, 0, -98, -181, -237};
  int tw_im [8] = '{0, -98, -181, -237, -256, -237, -181, -98};

  // Expected results in output order, kind 1 marks a sum
  fft_pkg::cplx_t exp_q [$];
  bit kind_q [$];
  fft_pkg::cplx_t exp_v;
  bit exp_sum;
  bit want_dif = 1'b0;
  bit in_burst = 1'b0;
  bit rv_seen = 1'b0;
  int cycles;
  int prev;

  fft_bfly_top #(.MUL_LAT(MUL_LAT), .FIFO_DEPTH(8)) dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .sample_valid  (sample_valid),
    .sample_a      (sample_a),
    .sample_b      (sample_b),
    .twdl_idx      (twdl_idx),
    .res           (res),
    .res_valid     (res_valid),
    .bffr_ovrflw   (bffr_ovrflw),
    .bffr_underflw (bffr_underflw)
  );

  always #20 clk = ~clk;

  task automatic stop_on_error(input string why);
    begin
      $display("%s", why);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  // Model: b*W exact, >>> 8, keep 17 bits, then a +/- that wrapped to 16
  task automatic push_model(input fft_pkg::cplx_t a, input fft_pkg::cplx_t b,
                            input fft_pkg::twdl_idx_t k);
    longint p_re;
    longint p_im;
    logic signed [16:0] q_re;
    logic signed [16:0] q_im;
    fft_pkg::cplx_t sum_v;
    fft_pkg::cplx_t dif_v;
    begin
      p_re = longint'(b.re) * longint'(tw_re[k]) - longint'(b.im) * longint'(tw_im[k]);
      p_im = longint'(b.re) * longint'(tw_im[k]) + longint'(b.im) * longint'(tw_re[k]);
      q_re = 17'(p_re >>> 8);
      q_im = 17'(p_im >>> 8);
      sum_v.re = 16'(longint'(a.re) + longint'(q_re));
      sum_v.im = 16'(longint'(a.im) + longint'(q_im));
      dif_v.re = 16'(longint'(a.re) - longint'(q_re));
      dif_v.im = 16'(longint'(a.im) - longint'(q_im));
      exp_q.push_back(sum_v);
      kind_q.push_back(1'b1);
      exp_q.push_back(dif_v);
      kind_q.push_back(1'b0);
    end
  endtask

  // Drives one strobe with random samples, caller sits on a rising edge
  task automatic load_pair(input fft_pkg::twdl_idx_t k);
    fft_pkg::cplx_t a;
    fft_pkg::cplx_t b;
    begin
      a = $random(seed);
      b = $random(seed);
      sample_valid <= 1'b1;
      sample_a <= a;
      sample_b <= b;
      twdl_idx <= k;
      push_model(a, b, k);
    end
  endtask

  task automatic send_pair(input fft_pkg::twdl_idx_t k);
    begin
      @(posedge clk);
      load_pair(k);
      @(posedge clk);
      sample_valid <= 1'b0;
    end
  endtask

  // Waits until every expected result has come out
  task automatic drain(input int limit);
    int n;
    begin
      n = 0;
      while (exp_q.size() != 0 && n < limit)
      begin
        @(posedge clk);
        n++;
      end
      assert (exp_q.size() == 0)
        else stop_on_error("Timeout: expected results never appeared on res");
    end
  endtask

  // Output checker, sampled mid cycle
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      assert (!bffr_ovrflw) else stop_on_error("FIFO overflow flag went high");
      assert (!bffr_underflw) else stop_on_error("FIFO underflow flag went high");
      assert (!want_dif || res_valid)
        else stop_on_error("Difference did not follow its sum on the next cycle");
      want_dif = 1'b0;
      if (res_valid)
      begin
        assert (exp_q.size() != 0) else stop_on_error("res_valid high with nothing expected");
        exp_v = exp_q.pop_front();
        exp_sum = kind_q.pop_front();
        assert (res.re == exp_v.re)
          else stop_on_error($sformatf("Error: %0t res.re expected %h got %h",
                                       $time, exp_v.re, res.re));
        assert (res.im == exp_v.im)
          else stop_on_error($sformatf("Error: %0t res.im expected %h got %h",
                                       $time, exp_v.im, res.im));
        want_dif = exp_sum;
        rv_seen = rv_seen | in_burst;
      end
      else if (in_burst && rv_seen)
      begin
        assert (exp_q.size() == 0) else stop_on_error("Gap in res_valid during the burst");
      end
    end
  end

  initial
  begin
    rst_n = 1'b0;
    sample_valid = 1'b0;
    sample_a = '0;
    sample_b = '0;
    twdl_idx = '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    assert (!res_valid && !bffr_ovrflw && !bffr_underflw)
      else stop_on_error("Outputs not idle after reset");

    // Isolated strobes, one per twiddle index, with latency check
    for (int k = 0; k < 8; k++)
    begin
      send_pair(fft_pkg::twdl_idx_t'(k));
      cycles = 0;
      while (cycles < 20)
      begin
        @(posedge clk);
        cycles++;
        @(negedge clk);
        if (res_valid)
        begin
          break;
        end
      end
      assert (res_valid) else stop_on_error("Timeout: no res_valid after an isolated strobe");
      assert (cycles == MUL_LAT + 2)
        else stop_on_error($sformatf("Error: %0t res_valid latency expected %0d got %0d",
                                     $time, MUL_LAT + 2, cycles));
      @(negedge clk);
      assert (res_valid) else stop_on_error("Second result missing one cycle after the first");
      @(negedge clk);
      assert (!res_valid) else stop_on_error("Extra result after an isolated pair");
      drain(20);
    end

    // Random strobes, never on two cycles in a row
    prev = 0;
    for (int i = 0; i < 400; i++)
    begin
      @(posedge clk);
      if (prev == 0 && ($random(seed) & 1) != 0)
      begin
        load_pair(fft_pkg::twdl_idx_t'($random(seed) & 7));
        prev = 1;
      end
      else
      begin
        sample_valid <= 1'b0;
        prev = 0;
      end
    end
    @(posedge clk);
    sample_valid <= 1'b0;
    drain(40);

    // Full rate burst, one strobe every second cycle
    rv_seen = 1'b0;
    in_burst = 1'b1;
    for (int i = 0; i < N_BURST; i++)
    begin
      send_pair(fft_pkg::twdl_idx_t'($random(seed) & 7));
    end
    drain(40);
    in_burst = 1'b0;
    // Quiet tail so a stray result still hits the checker
    repeat (4) @(posedge clk);
    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: verilog/fft_bfly_top.sv
`timescale 1ns/10ps

module fft_bfly_top #(
  parameter int MUL_LAT    = 3,
  parameter int FIFO_DEPTH = 8
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                sample_valid,
  input  fft_pkg::cplx_t      sample_a,
  input  fft_pkg::cplx_t      sample_b,
  input  fft_pkg::twdl_idx_t  twdl_idx,
  output fft_pkg::cplx_t      res,
  output logic                res_valid,
  output logic                bffr_ovrflw,
  output logic                bffr_underflw
);

  // Twiddle for the current index, same cycle as the strobe
  fft_pkg::twdl_t twdl;

  twiddle_rom u_rom (
    .idx  (twdl_idx),
    .twdl (twdl)
  );

  but_wing #(
    .MUL_LAT    (MUL_LAT),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_bfly (
    .clk           (clk),
    .rst_n         (rst_n),
    .sample_a      (sample_a),
    .sample_b      (sample_b),
    .twdl          (twdl),
    .sample_valid  (sample_valid),
    .res           (res),
    .res_valid     (res_valid),
    .bffr_ovrflw   (bffr_ovrflw),
    .bffr_underflw (bffr_underflw)
  );

endmodule

// File: verilog/but_wing.sv
`timescale 1ns/10ps

module but_wing #(
  parameter int MUL_LAT    = 3,
  parameter int FIFO_DEPTH = 8
) (
  input  logic            clk,
  input  logic            rst_n,
  input  fft_pkg::cplx_t  sample_a,
  input  fft_pkg::cplx_t  sample_b,
  input  fft_pkg::twdl_t  twdl,
  input  logic            sample_valid,
  output fft_pkg::cplx_t  res,
  output logic            res_valid,
  output logic            bffr_ovrflw,
  output logic            bffr_underflw
);

  localparam int PST_W = MUL_LAT + 2;
  localparam int SW    = fft_pkg::sample_w;

  // Normalized product, one bit wider than a sample
  typedef struct packed {
    logic signed [SW:0] re;
    logic signed [SW:0] im;
  } norm_t;

  // Strobe history, bit k set k+1 edges after the strobe
  logic [PST_W-1:0] pst_vec;

  fft_pkg::prod_t prod;
  fft_pkg::cplx_t head;
  logic           fifo_full;
  logic           fifo_empty;

  logic signed [fft_pkg::mul_w-1:0] shr_re;
  logic signed [fft_pkg::mul_w-1:0] shr_im;

  norm_t norm_c;
  norm_t norm_q;
  norm_t neg_q;
  norm_t sum_c;
  norm_t dif_c;

  // Difference waits here for its output slot
  fft_pkg::cplx_t dif_q;
  logic           dif_phase;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pst_vec <= '0;
    end
    else
    begin
      pst_vec <= {pst_vec[PST_W-2:0], sample_valid};
    end
  end

  // Divide by 1.0 of the twiddle scale, then drop to SW+1 bits
  assign shr_re    = prod.re >>> fft_pkg::twdl_shift;
  assign shr_im    = prod.im >>> fft_pkg::twdl_shift;
  assign norm_c.re = shr_re[SW:0];
  assign norm_c.im = shr_im[SW:0];

  // Product valid for one cycle only
  always_ff @(posedge clk)
  begin
    if (pst_vec[MUL_LAT-1])
    begin
      norm_q   <= norm_c;
      neg_q.re <= -norm_c.re;
      neg_q.im <= -norm_c.im;
    end
  end

  // Head sign extended, sums wrap
  assign sum_c.re = {head.re[SW-1], head.re} + norm_q.re;
  assign sum_c.im = {head.im[SW-1], head.im} + norm_q.im;
  assign dif_c.re = {head.re[SW-1], head.re} + neg_q.re;
  assign dif_c.im = {head.im[SW-1], head.im} + neg_q.im;

  // Both results taken together, before the next product lands
  always_ff @(posedge clk)
  begin
    if (pst_vec[MUL_LAT+1])
    begin
      dif_q <= '{re: dif_c.re[SW-1:0], im: dif_c.im[SW-1:0]};
    end
  end

  // Sum first, difference on the following cycle
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      res       <= '0;
      res_valid <= 1'b0;
      dif_phase <= 1'b0;
    end
    else
    begin
      res_valid <= pst_vec[MUL_LAT+1] | dif_phase;
      dif_phase <= pst_vec[MUL_LAT+1];
      if (pst_vec[MUL_LAT+1])
      begin
        res <= '{re: sum_c.re[SW-1:0], im: sum_c.im[SW-1:0]};
      end
      else if (dif_phase)
      begin
        res <= dif_q;
      end
    end
  end

  cplx_mult #(
    .LAT (MUL_LAT)
  ) u_mult (
    .clk   (clk),
    .rst_n (rst_n),
    .a     (sample_b),
    .w     (twdl),
    .p     (prod)
  );

  // Pop once the difference is out
  sample_fifo #(
    .T     (fft_pkg::cplx_t),
    .DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_en   (sample_valid),
    .wr_data (sample_a),
    .rd_en   (dif_phase),
    .rd_data (head),
    .full    (fifo_full),
    .empty   (fifo_empty)
  );

  assign bffr_ovrflw   = sample_valid & fifo_full;
  assign bffr_underflw = pst_vec[MUL_LAT+1] & fifo_empty;

endmodule

// File: verilog/twiddle_rom.sv
`timescale 1ns/10ps

module twiddle_rom (
  input  fft_pkg::twdl_idx_t  idx,
  output fft_pkg::twdl_t      twdl
);

  // W(k) = cos(2*pi*k/16) - j*sin(2*pi*k/16), Q8, rounded
  always_comb
  begin
    case (idx)
      3'd0:
      begin
        twdl = '{re: 10'sd256, im: 10'sd0};
      end
      3'd1:
      begin
        twdl = '{re: 10'sd237, im: -10'sd98};
      end
      3'd2:
      begin
        twdl = '{re: 10'sd181, im: -10'sd181};
      end
      3'd3:
      begin
        twdl = '{re: 10'sd98, im: -10'sd237};
      end
      // Quarter turn, pure -j
      3'd4:
      begin
        twdl = '{re: 10'sd0, im: -10'sd256};
      end
      3'd5:
      begin
        twdl = '{re: -10'sd98, im: -10'sd237};
      end
      3'd6:
      begin
        twdl = '{re: -10'sd181, im: -10'sd181};
      end
      default:
      begin
        twdl = '{re: -10'sd237, im: -10'sd98};
      end
    endcase
  end

endmodule

// File: verilog/sample_fifo.sv
`timescale 1ns/10ps

module sample_fifo #(
  parameter type T     = logic [31:0],
  parameter int  DEPTH = 8
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  wr_en,
  input  T      wr_data,
  input  logic  rd_en,
  output T      rd_data,
  output logic  full,
  output logic  empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // Storage, no reset on the data
  T mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  // One extra bit so DEPTH itself fits
  logic [PTR_W:0]   count;

  // Qualified requests, bad ones dropped
  logic do_wr;
  logic do_rd;

  assign full  = (count == (PTR_W+1)'(DEPTH));
  assign empty = (count == '0);

  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  // Head entry always visible
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (do_wr)
    begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      // Pointers wrap at DEPTH, which need not be a power of two
      if (do_wr)
      begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd)
      begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves count alone
      if (do_wr && !do_rd)
      begin
        count <= count + 1'b1;
      end
      else if (do_rd && !do_wr)
      begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// File: verilog/cplx_mult.sv
`timescale 1ns/10ps

module cplx_mult #(
  parameter int LAT = 3
) (
  input  logic            clk,
  input  logic            rst_n,
  input  fft_pkg::cplx_t  a,
  input  fft_pkg::twdl_t  w,
  output fft_pkg::prod_t  p
);

  localparam int PP_W = fft_pkg::sample_w + fft_pkg::twdl_w;

  // Partial products, stage one
  logic signed [PP_W-1:0] pp_rr;
  logic signed [PP_W-1:0] pp_ii;
  logic signed [PP_W-1:0] pp_ri;
  logic signed [PP_W-1:0] pp_ir;

  // Combined product, stage two
  fft_pkg::prod_t p_s2;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pp_rr <= '0;
      pp_ii <= '0;
      pp_ri <= '0;
      pp_ir <= '0;
      p_s2  <= '0;
    end
    else
    begin
      pp_rr <= a.re * w.re;
      pp_ii <= a.im * w.im;
      pp_ri <= a.re * w.im;
      pp_ir <= a.im * w.re;
      // Sign extended into mul_w before the add
      p_s2.re <= pp_rr - pp_ii;
      p_s2.im <= pp_ri + pp_ir;
    end
  end

  // Extra delay to reach LAT, none when LAT is 2
  if (LAT > 2)
  begin : g_dly
    fft_pkg::prod_t dly_q [LAT-2];

    always_ff @(posedge clk or negedge rst_n)
    begin
      if (!rst_n)
      begin
        for (int i = 0; i < LAT - 2; i++)
        begin
          dly_q[i] <= '0;
        end
      end
      else
      begin
        dly_q[0] <= p_s2;
        for (int i = 1; i < LAT - 2; i++)
        begin
          dly_q[i] <= dly_q[i-1];
        end
      end
    end

    assign p = dly_q[LAT-3];
  end
  else
  begin : g_nodly
    assign p = p_s2;
  end

endmodule

// File: verilog/fft_pkg.sv
package fft_pkg;

  // Sample word width, signed two's complement
  localparam int sample_w = 16;

  // Twiddle component width, Q8 so that 1.0 is 256
  localparam int twdl_w = 10;

  // Shift that takes a product back to sample scale
  localparam int twdl_shift = twdl_w - 2;

  // Full complex product width, one guard bit for the add
  localparam int mul_w = sample_w + twdl_w + 1;

  // Transform size and twiddle index width
  localparam int fft_points = 16;
  localparam int twdl_idx_w = $clog2(fft_points / 2);

  typedef logic [twdl_idx_w-1:0] twdl_idx_t;

  // Complex sample, real part in the upper word
  typedef struct packed {
    logic signed [sample_w-1:0] re;
    logic signed [sample_w-1:0] im;
  } cplx_t;

  typedef struct packed {
    logic signed [twdl_w-1:0] re;
    logic signed [twdl_w-1:0] im;
  } twdl_t;

  typedef struct packed {
    logic signed [mul_w-1:0] re;
    logic signed [mul_w-1:0] im;
  } prod_t;

endpackage
